// ==== src/reflet_addr.sv ====
`timescale 1ns/1ps
`default_nettype none

module reflet_addr #(
    parameter int wordsize = 16
)(
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic [wordsize-1:0] working_register,
    input  logic [wordsize-1:0] stack_pointer,
    input  logic [wordsize-1:0] program_counter,
    input  logic [wordsize-1:0] other_register,
    input  logic [wordsize-1:0] data_in,
    output logic [wordsize-1:0] addr,
    output logic [wordsize-1:0] data_out,
    output logic                write_en,
    output logic [7:0]          instruction,
    output logic                retire,
    output logic                quit,
    output logic                debug,
    reflet_result_if.unit       res
);
    reflet_pkg::cpu_state_t state;
    reflet_pkg::cpu_state_t next_state;
    reflet_pkg::opcode_t    opcode;
    reflet_pkg::opcode_t    fetched_op;
    logic [wordsize-1:0]    load_data;

    assign opcode     = reflet_pkg::opcode_t'(instruction[7:4]);
    // memory answers the fetch while in decode
    assign fetched_op = reflet_pkg::opcode_t'(data_in[7:4]);

    assign retire = enable && state == reflet_pkg::retire;

    always_comb
    begin
        next_state = state;
        case (state)
            reflet_pkg::fetch:
                next_state = reflet_pkg::decode;
            reflet_pkg::decode:
                if (fetched_op inside {reflet_pkg::load, reflet_pkg::store,
                                       reflet_pkg::push, reflet_pkg::pop})
                    next_state = reflet_pkg::access;
                else
                    next_state = reflet_pkg::retire;
            reflet_pkg::access:
                // writes finish here, reads need the extra wait cycle
                if (opcode == reflet_pkg::load || opcode == reflet_pkg::pop)
                    next_state = reflet_pkg::access_wait;
                else
                    next_state = reflet_pkg::retire;
            reflet_pkg::access_wait:
                next_state = reflet_pkg::retire;
            reflet_pkg::retire:
                if (instruction == reflet_pkg::inst_quit)
                    next_state = reflet_pkg::halted;
                else
                    next_state = reflet_pkg::fetch;
            default:
                next_state = reflet_pkg::halted;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state       <= reflet_pkg::fetch;
            instruction <= 8'h00;
            quit        <= 1'b0;
            debug       <= 1'b0;
        end
        else
        begin
            // single pulse even if enable drops right after
            debug <= retire && instruction == reflet_pkg::inst_debug;
            if (enable)
            begin
                state <= next_state;
                if (state == reflet_pkg::decode)
                    instruction <= data_in[7:0];
                if (retire && instruction == reflet_pkg::inst_quit)
                    quit <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (enable && state == reflet_pkg::access_wait)
            load_data <= data_in;
    end

    // address stays put through the wait cycle so a stall rereads the same word
    always_comb
    begin
        addr = program_counter;
        if (state == reflet_pkg::access || state == reflet_pkg::access_wait)
        begin
            case (opcode)
                reflet_pkg::push: addr = stack_pointer;
                // pop reads below the current top
                reflet_pkg::pop:  addr = stack_pointer - 1'b1;
                default:          addr = other_register;
            endcase
        end
    end

    assign data_out = (opcode == reflet_pkg::push) ? other_register : working_register;
    assign write_en = enable && state == reflet_pkg::access &&
                      (opcode == reflet_pkg::store || opcode == reflet_pkg::push);

    always_comb
    begin
        res.index   = reflet_pkg::wr_id;
        res.content = load_data;
        res.write   = 1'b0;
        res.sp_step = reflet_pkg::sp_hold;
        res.pc_load = 1'b0;
        case (opcode)
            reflet_pkg::load:
                res.write = 1'b1;
            reflet_pkg::pop:
            begin
                res.index   = instruction[3:0];
                res.write   = 1'b1;
                res.sp_step = reflet_pkg::sp_dec;
            end
            reflet_pkg::push:
                res.sp_step = reflet_pkg::sp_inc;
            reflet_pkg::jif:
            begin
                res.content = other_register;
                res.pc_load = 1'b1;
            end
            default:
                res.write = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/reflet_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module reflet_alu #(
    parameter int wordsize = 16
)(
    input  logic [7:0]          instruction,
    input  logic [wordsize-1:0] working_register,
    input  logic [wordsize-1:0] status_register,
    input  logic [wordsize-1:0] other_register,
    reflet_result_if.unit       res
);
    reflet_pkg::opcode_t opcode;
    logic [wordsize-1:0] immediate;

    assign opcode = reflet_pkg::opcode_t'(instruction[7:4]);
    assign immediate = {{(wordsize-4){1'b0}}, instruction[3:0]};

    always_comb
    begin
        // default target is the working register
        res.index   = reflet_pkg::wr_id;
        res.content = working_register;
        res.write   = 1'b0;
        res.sp_step = reflet_pkg::sp_hold;
        res.pc_load = 1'b0;
        if (instruction == reflet_pkg::inst_not)
        begin
            res.content = ~working_register;
            res.write   = 1'b1;
        end
        else
        begin
            res.write = 1'b1;
            case (opcode)
                reflet_pkg::set:    res.content = immediate;
                reflet_pkg::read:   res.content = other_register;
                reflet_pkg::cpy:
                begin
                    res.index   = instruction[3:0];
                    res.content = working_register;
                end
                reflet_pkg::add:    res.content = working_register + other_register;
                reflet_pkg::sub:    res.content = working_register - other_register;
                reflet_pkg::and_op: res.content = working_register & other_register;
                reflet_pkg::or_op:  res.content = working_register | other_register;
                reflet_pkg::xor_op: res.content = working_register ^ other_register;
                // comparisons only touch status bit 0
                reflet_pkg::eq:
                begin
                    res.index   = reflet_pkg::sr_id;
                    res.content = {status_register[wordsize-1:1],
                                   working_register == other_register};
                end
                reflet_pkg::less:
                begin
                    // unsigned compare
                    res.index   = reflet_pkg::sr_id;
                    res.content = {status_register[wordsize-1:1],
                                   working_register < other_register};
                end
                // slp row and the bus opcodes belong to the address unit
                default:            res.write = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/reflet_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module reflet_cpu #(
    parameter int wordsize = 16
)(
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic [wordsize-1:0] data_in,
    output logic [wordsize-1:0] addr,
    output logic [wordsize-1:0] data_out,
    output logic                write_en,
    output logic                quit,
    output logic                debug
);
    logic [7:0]          instruction;
    logic                retire;
    logic [wordsize-1:0] working_register;
    logic [wordsize-1:0] status_register;
    logic [wordsize-1:0] stack_pointer;
    logic [wordsize-1:0] program_counter;
    logic [wordsize-1:0] other_register;

    reflet_result_if #(.wordsize(wordsize)) alu_res ();
    reflet_result_if #(.wordsize(wordsize)) mem_res ();

    reflet_alu #(.wordsize(wordsize)) alu (
        .instruction      (instruction),
        .working_register (working_register),
        .status_register  (status_register),
        .other_register   (other_register),
        .res              (alu_res)
    );

    // sequencer and memory bus
    reflet_addr #(.wordsize(wordsize)) bus_unit (
        .clk              (clk),
        .reset            (reset),
        .enable           (enable),
        .working_register (working_register),
        .stack_pointer    (stack_pointer),
        .program_counter  (program_counter),
        .other_register   (other_register),
        .data_in          (data_in),
        .addr             (addr),
        .data_out         (data_out),
        .write_en         (write_en),
        .instruction      (instruction),
        .retire           (retire),
        .quit             (quit),
        .debug            (debug),
        .res              (mem_res)
    );

    reflet_regs #(.wordsize(wordsize)) reg_file (
        .clk              (clk),
        .reset            (reset),
        .enable           (enable),
        .instruction      (instruction),
        .retire           (retire),
        .alu_res          (alu_res),
        .mem_res          (mem_res),
        .working_register (working_register),
        .status_register  (status_register),
        .stack_pointer    (stack_pointer),
        .program_counter  (program_counter),
        .other_register   (other_register)
    );

endmodule

`default_nettype wire

// ==== src/reflet_pkg.sv ====
`default_nettype none

package reflet_pkg;

    // high nibble of an instruction, the low nibble is the register argument
    // row 0 holds the argument-free codes, so the inversion lives there as a
    // full-byte code and not as its own opcode
    typedef enum logic [3:0] {
        slp    = 4'h0,
        set    = 4'h1,
        read   = 4'h2,
        cpy    = 4'h3,
        add    = 4'h4,
        sub    = 4'h5,
        and_op = 4'h6,
        or_op  = 4'h7,
        xor_op = 4'h8,
        eq     = 4'h9,
        less   = 4'hA,
        load   = 4'hB,
        store  = 4'hC,
        push   = 4'hD,
        pop    = 4'hE,
        jif    = 4'hF
    } opcode_t;

    // full-byte codes in the slp row, any other slp byte does nothing
    localparam logic [7:0] inst_not   = 8'h01;
    localparam logic [7:0] inst_debug = 8'h0E;
    localparam logic [7:0] inst_quit  = 8'h0F;

    // fixed register roles
    localparam logic [3:0] wr_id = 4'd0;
    localparam logic [3:0] sr_id = 4'd1;
    localparam logic [3:0] sp_id = 4'd2;
    localparam logic [3:0] pc_id = 4'd3;

    // cut down to the word size where it is used
    localparam logic [31:0] sp_reset = 32'h0000_00F0;

    // instruction sequencer
    typedef enum logic [2:0] {
        fetch,
        decode,
        access,
        access_wait,
        retire,
        halted
    } cpu_state_t;

    // what the stack pointer does when an instruction retires
    typedef enum logic [1:0] {
        sp_hold,
        sp_inc,
        sp_dec
    } sp_step_t;

endpackage

`default_nettype wire

// ==== src/reflet_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module reflet_regs #(
    parameter int wordsize = 16
)(
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic [7:0]          instruction,
    input  logic                retire,
    reflet_result_if.regs       alu_res,
    reflet_result_if.regs       mem_res,
    output logic [wordsize-1:0] working_register,
    output logic [wordsize-1:0] status_register,
    output logic [wordsize-1:0] stack_pointer,
    output logic [wordsize-1:0] program_counter,
    output logic [wordsize-1:0] other_register
);
    logic [wordsize-1:0]  registers [16];
    reflet_pkg::sp_step_t sp_step;
    logic                 pc_load;
    logic                 jump_taken;
    logic [wordsize-1:0]  jump_target;

    assign working_register = registers[reflet_pkg::wr_id];
    assign status_register  = registers[reflet_pkg::sr_id];
    assign stack_pointer    = registers[reflet_pkg::sp_id];
    assign program_counter  = registers[reflet_pkg::pc_id];
    assign other_register   = registers[instruction[3:0]];

    // address unit has priority on the step and jump fields
    assign sp_step = (mem_res.sp_step != reflet_pkg::sp_hold) ? mem_res.sp_step
                                                              : alu_res.sp_step;
    assign pc_load     = mem_res.pc_load | alu_res.pc_load;
    assign jump_target = mem_res.pc_load ? mem_res.content : alu_res.content;
    assign jump_taken  = pc_load && status_register[0];

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 0; i < 16; i++)
                registers[i] <= '0;
            registers[reflet_pkg::sp_id] <= reflet_pkg::sp_reset[wordsize-1:0];
        end
        else if (enable && retire)
        begin
            case (sp_step)
                reflet_pkg::sp_inc: registers[reflet_pkg::sp_id] <= stack_pointer + 1'b1;
                reflet_pkg::sp_dec: registers[reflet_pkg::sp_id] <= stack_pointer - 1'b1;
                default:            registers[reflet_pkg::sp_id] <= stack_pointer;
            endcase

            if (jump_taken)
                registers[reflet_pkg::pc_id] <= jump_target;
            else
                registers[reflet_pkg::pc_id] <= program_counter + 1'b1;

            // explicit writes come last so they win over the sp and pc updates
            if (alu_res.write)
                registers[alu_res.index] <= alu_res.content;
            if (mem_res.write)
                registers[mem_res.index] <= mem_res.content;
        end
    end

endmodule

`default_nettype wire

// ==== src/reflet_result_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one unit's proposed register file update for the current instruction
interface reflet_result_if #(
    parameter int wordsize = 16
);
    logic [3:0]           index;
    logic [wordsize-1:0]  content;
    logic                 write;
    reflet_pkg::sp_step_t sp_step;
    // jump request, taken only when status bit 0 is set
    logic                 pc_load;

    modport unit (output index, output content, output write, output sp_step, output pc_load);

    modport regs (input index, input content, input write, input sp_step, input pc_load);

endinterface

`default_nettype wire

// ==== tb.f ====
src/reflet_pkg.sv
src/reflet_result_if.sv
src/reflet_alu.sv
src/reflet_addr.sv
src/reflet_regs.sv
src/reflet_cpu.sv
verif/reflet_cpu_properties.sv
verif/tb_reflet_cpu.sv

// ==== verif/reflet_cpu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module reflet_cpu_properties (
    input wire clk,
    input wire reset,
    input wire write_en,
    input wire quit,
    input wire debug,
    input wire retire
);

    int failures = 0;

    // halted core stays off the bus
    assert property (@(posedge clk) disable iff (!reset) quit |-> !write_en)
        else
        begin
            failures++;
            $error("write_en high while quit is set");
        end

    assert property (@(posedge clk) disable iff (!reset) quit |=> quit)
        else
        begin
            failures++;
            $error("quit fell without reset");
        end

    assert property (@(posedge clk) disable iff (!reset) debug |=> !debug)
        else
        begin
            failures++;
            $error("debug pulse longer than one cycle");
        end

    assert property (@(posedge clk) disable iff (!reset) retire |=> !retire)
        else
        begin
            failures++;
            $error("retire high for two cycles in a row");
        end

endmodule

bind reflet_cpu reflet_cpu_properties props (
    .clk      (clk),
    .reset    (reset),
    .write_en (write_en),
    .quit     (quit),
    .debug    (debug),
    .retire   (retire)
);

`default_nettype wire

// ==== verif/tb_reflet_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_reflet_cpu;

    localparam int wordsize = 16;
    localparam int period   = 4;
    localparam int n_tests  = 24;
    localparam int max_len  = 64;

    logic                clk = 1'b0;
    logic                reset = 1'b0;
    logic                enable = 1'b0;
    logic [wordsize-1:0] data_in = '0;
    logic [wordsize-1:0] addr;
    logic [wordsize-1:0] data_out;
    logic                write_en;
    logic                quit;
    logic                debug;

    logic [wordsize-1:0] mem [256];
    logic [wordsize-1:0] ref_mem [256];
    logic [wordsize-1:0] r [16];
    logic [7:0]          prog [256];
    logic [wordsize-1:0] got_addr [$];
    logic [wordsize-1:0] got_data [$];
    time                 got_time [$];
    logic [wordsize-1:0] exp_addr [$];
    logic [wordsize-1:0] exp_data [$];
    logic [wordsize-1:0] model_pc;
    logic [31:0]         prog_rng;
    logic [31:0]         stall_rng;
    int                  prog_len;
    int                  model_cycles;
    int                  debug_expected;
    int                  debug_seen;
    int                  cycles_seen;
    int                  errors;
    int                  failed_tests;

    reflet_cpu #(.wordsize(wordsize)) UUT (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  (data_in),
        .addr     (addr),
        .data_out (data_out),
        .write_en (write_en),
        .quit     (quit),
        .debug    (debug)
    );

    always #(period / 2) clk = ~clk;

    // memory with one cycle read latency, plus write and pulse recording
    always @(posedge clk)
    begin
        data_in <= mem[addr[7:0]];
        if (write_en)
        begin
            mem[addr[7:0]] <= data_out;
            got_addr.push_back(addr);
            got_data.push_back(data_out);
            got_time.push_back($time);
        end
        if (debug)
            debug_seen++;
        if (reset && enable && !quit)
            cycles_seen++;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int pick(input int n);
        prog_rng = xorshift(prog_rng);
        return int'(prog_rng[15:0]) % n;
    endfunction

    function automatic logic [3:0] gp_reg();
        return 4'(4 + pick(12));
    endfunction

    // working register or general purpose but never sr, sp or pc
    function automatic logic [3:0] dst_reg();
        int n;
        n = pick(13);
        return (n == 0) ? 4'd0 : 4'(n + 3);
    endfunction

    function automatic void emit(input logic [7:0] code);
        prog[prog_len] = code;
        prog_len++;
    endfunction

    // opcodes 1 to 10 are set, read, cpy and the register ALU ops
    function automatic logic [7:0] alu_inst();
        int op;
        op = pick(11);
        if (op == 0)
            return reflet_pkg::inst_not;
        if (op == 3)
            return {reflet_pkg::cpy, dst_reg()};
        return {4'(op), 4'(pick(16))};
    endfunction

    task automatic build_program();
        int         depth;
        int         n;
        logic [3:0] a;
        logic [3:0] b;
        prog_len = 0;
        depth = 0;
        while (prog_len < max_len - 12)
        begin
            case (pick(8))
                3:
                begin
                    // set then not gives an address in the 0xF0..0xFF window
                    a = gp_reg();
                    emit({reflet_pkg::set, 4'(pick(16))});
                    emit(reflet_pkg::inst_not);
                    emit({reflet_pkg::cpy, a});
                    emit({reflet_pkg::read, 4'(pick(16))});
                    emit({reflet_pkg::store, a});
                end
                4:
                begin
                    a = gp_reg();
                    emit({reflet_pkg::set, 4'(pick(16))});
                    emit(reflet_pkg::inst_not);
                    emit({reflet_pkg::cpy, a});
                    emit({reflet_pkg::load, a});
                    emit({reflet_pkg::cpy, gp_reg()});
                end
                5:
                begin
                    if (depth < 12 && (depth == 0 || pick(2) == 1))
                    begin
                        emit({reflet_pkg::push, 4'(pick(16))});
                        depth++;
                    end
                    else
                    begin
                        emit({reflet_pkg::pop, dst_reg()});
                        depth--;
                    end
                end
                6:
                begin
                    // jif target lands just past the n skipped codes
                    n = 1 + pick(4);
                    a = gp_reg();
                    b = gp_reg();
                    emit({reflet_pkg::set, 4'(n + 5)});
                    emit({reflet_pkg::cpy, b});
                    emit({reflet_pkg::read, reflet_pkg::pc_id});
                    emit({reflet_pkg::add, b});
                    emit({reflet_pkg::cpy, a});
                    emit({pick(2) ? reflet_pkg::eq : reflet_pkg::less, 4'(pick(16))});
                    emit({reflet_pkg::jif, a});
                    repeat (n)
                    begin
                        // depth counts a push here even when the jump skips it
                        if (depth < 12 && pick(4) == 0)
                        begin
                            emit({reflet_pkg::push, 4'(pick(16))});
                            depth++;
                        end
                        else
                            emit(alu_inst());
                    end
                end
                7:
                    emit(pick(2) ? reflet_pkg::inst_debug : 8'h00);
                default:
                    emit(alu_inst());
            endcase
        end
        emit(reflet_pkg::inst_quit);
        for (int i = 0; i < 256; i++)
        begin
            mem[i] = (i < prog_len) ? {8'h00, prog[i]} : 16'(pick(65536));
            ref_mem[i] = mem[i];
        end
    endtask

    task automatic run_model();
        logic [7:0]          inst;
        logic [3:0]          a;
        logic [wordsize-1:0] next_pc;
        for (int i = 0; i < 16; i++)
            r[i] = '0;
        r[reflet_pkg::sp_id] = 16'h00F0;
        model_cycles = 0;
        debug_expected = 0;
        exp_addr.delete();
        exp_data.delete();
        for (int steps = 0; steps < 1000; steps++)
        begin
            inst = ref_mem[r[3][7:0]][7:0];
            a = inst[3:0];
            next_pc = r[3] + 1'b1;
            if (inst == reflet_pkg::inst_quit)
            begin
                model_cycles += 3;
                model_pc = next_pc;
                break;
            end
            case (reflet_pkg::opcode_t'(inst[7:4]))
                reflet_pkg::load, reflet_pkg::pop:   model_cycles += 5;
                reflet_pkg::store, reflet_pkg::push: model_cycles += 4;
                default:                             model_cycles += 3;
            endcase
            if (inst == reflet_pkg::inst_not)
                r[0] = ~r[0];
            else if (inst == reflet_pkg::inst_debug)
                debug_expected++;
            else
                case (reflet_pkg::opcode_t'(inst[7:4]))
                    reflet_pkg::set:    r[0] = wordsize'(a);
                    reflet_pkg::read:   r[0] = r[a];
                    reflet_pkg::cpy:    r[a] = r[0];
                    reflet_pkg::add:    r[0] = r[0] + r[a];
                    reflet_pkg::sub:    r[0] = r[0] - r[a];
                    reflet_pkg::and_op: r[0] = r[0] & r[a];
                    reflet_pkg::or_op:  r[0] = r[0] | r[a];
                    reflet_pkg::xor_op: r[0] = r[0] ^ r[a];
                    reflet_pkg::eq:     r[1][0] = (r[0] == r[a]);
                    reflet_pkg::less:   r[1][0] = (r[0] < r[a]);
                    reflet_pkg::load:   r[0] = ref_mem[r[a][7:0]];
                    reflet_pkg::store:
                    begin
                        exp_addr.push_back(r[a]);
                        exp_data.push_back(r[0]);
                        ref_mem[r[a][7:0]] = r[0];
                    end
                    reflet_pkg::push:
                    begin
                        exp_addr.push_back(r[2]);
                        exp_data.push_back(r[a]);
                        ref_mem[r[2][7:0]] = r[a];
                        r[2] = r[2] + 1'b1;
                    end
                    reflet_pkg::pop:
                    begin
                        r[2] = r[2] - 1'b1;
                        r[a] = ref_mem[r[2][7:0]];
                    end
                    reflet_pkg::jif:    next_pc = r[1][0] ? r[a] : next_pc;
                    default:            ;
                endcase
            r[3] = next_pc;
        end
    endtask

    task automatic run_test(input int t, input bit stall);
        int n;
        int test_errors;
        test_errors = 0;
        @(posedge clk);
        reset  <= 1'b0;
        enable <= 1'b1;
        build_program();
        run_model();
        got_addr.delete();
        got_data.delete();
        got_time.delete();
        debug_seen = 0;
        cycles_seen = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b1;
        n = 0;
        while (quit !== 1'b1 && n < max_len * 10 + 20)
        begin
            @(posedge clk);
            n++;
            stall_rng = xorshift(stall_rng);
            enable <= !stall || stall_rng[2:0] != 3'd0;
        end
        enable <= 1'b1;
        if (quit !== 1'b1)
        begin
            $display("test %0d: quit never rose within %0d cycles", t, n);
            test_errors++;
        end
        else if (cycles_seen != model_cycles)
        begin
            $display("MISMATCH %0t: test %0d quit after %0d cycles, expected %0d",
                     $time, t, cycles_seen, model_cycles);
            test_errors++;
        end
        // halted core must hold quit and stay off the bus
        repeat (8)
        begin
            @(posedge clk);
            if (quit !== 1'b1)
            begin
                $display("test %0d: quit dropped while halted", t);
                test_errors++;
            end
        end
        if (addr !== model_pc)
        begin
            $display("MISMATCH %0t: test %0d final pc %h, expected %h", $time, t, addr, model_pc);
            test_errors++;
        end
        if (debug_seen != debug_expected)
        begin
            $display("test %0d: saw %0d debug pulses instead of %0d", t, debug_seen,
                     debug_expected);
            test_errors++;
        end
        if (got_addr.size() != exp_addr.size())
        begin
            $display("test %0d: core made %0d writes but %0d were expected", t,
                     got_addr.size(), exp_addr.size());
            test_errors++;
        end
        for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++)
        begin
            if (got_addr[i] !== exp_addr[i] || got_data[i] !== exp_data[i])
            begin
                $display("MISMATCH %0t: test %0d write %0d at %0t wrote %h to %h, expected %h to %h",
                         $time, t, i, got_time[i], got_data[i], got_addr[i], exp_data[i],
                         exp_addr[i]);
                test_errors++;
            end
        end
        errors += test_errors;
        if (test_errors != 0)
            failed_tests++;
        $display("test %0d: %0d codes, %0d writes, %0d cycles, stalls %0d, %0d errors",
                 t, prog_len, exp_addr.size(), model_cycles, stall, test_errors);
    endtask

    initial
    begin
        prog_rng = 32'd87454;
        stall_rng = xorshift(32'd87454);
        errors = 0;
        failed_tests = 0;
        for (int t = 0; t < n_tests; t++)
            run_test(t, t % 2 == 1);
        errors += UUT.props.failures;
        $display("%0d tests run, %0d failed, %0d errors", n_tests, failed_tests, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // longest program at five cycles per code, plus reset and halt margin
    initial
    begin
        #(n_tests * (max_len * 5 + 20) * period);
        $display("watchdog expired before all tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
